/* mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

   localparam int opcodeW = 6;
   localparam int functW  = 6;
   localparam int shamtW  = 5;
   localparam int immW    = 16;

   typedef logic [opcodeW-1:0] opcodeT;
   typedef logic [functW-1:0]  functT;
   typedef logic [shamtW-1:0]  shamtT;
   typedef logic [immW-1:0]    immT;

   localparam opcodeT opRType = 6'b000000;  // decoded further by funct
   localparam opcodeT opJ     = 6'b000010;
   localparam opcodeT opJal   = 6'b000011;
   localparam opcodeT opBeq   = 6'b000100;
   localparam opcodeT opBne   = 6'b000101;
   localparam opcodeT opAddi  = 6'b001000;
   localparam opcodeT opAddiu = 6'b001001;
   localparam opcodeT opSlti  = 6'b001010;
   localparam opcodeT opSltiu = 6'b001011;
   localparam opcodeT opAndi  = 6'b001100;
   localparam opcodeT opOri   = 6'b001101;
   localparam opcodeT opXori  = 6'b001110;
   localparam opcodeT opLw    = 6'b100011;
   localparam opcodeT opSw    = 6'b101011;

   localparam functT fnSll  = 6'b000000;
   localparam functT fnSrl  = 6'b000010;
   localparam functT fnSra  = 6'b000011;
   localparam functT fnSllv = 6'b000100;
   localparam functT fnSrlv = 6'b000110;
   localparam functT fnSrav = 6'b000111;
   localparam functT fnJr   = 6'b001000;
   localparam functT fnAdd  = 6'b100000;
   localparam functT fnAddu = 6'b100001;
   localparam functT fnSub  = 6'b100010;
   localparam functT fnSubu = 6'b100011;
   localparam functT fnAnd  = 6'b100100;
   localparam functT fnOr   = 6'b100101;
   localparam functT fnXor  = 6'b100110;
   localparam functT fnNor  = 6'b100111;
   localparam functT fnSlt  = 6'b101010;
   localparam functT fnSltu = 6'b101011;

endpackage

`default_nettype wire

/* exeTypesPkg.sv */
`default_nettype none

package exeTypesPkg;

   localparam int wordW = 32;

   typedef logic [wordW-1:0] wordT;

   // instruction fields as latched in ID/EX
   typedef struct packed {
      mipsIsaPkg::opcodeT opcode;
      mipsIsaPkg::functT  funct;
      mipsIsaPkg::shamtT  shamt;
      mipsIsaPkg::immT    imme;
   } exeFieldsT;

   typedef enum logic [1:0] {
      fwdRegFile   = 2'b00,
      fwdWriteback = 2'b01,
      fwdMemory    = 2'b10  // 2'b11 falls back to the register file
   } fwdSelT;

   typedef enum logic [1:0] {
      unitArith,
      unitLogic,
      unitLink,
      unitNone
   } unitSelT;

   typedef enum logic [2:0] {
      aAdd, aAddu, aSub, aSubu, aSlt, aSltu, aEq, aNe
   } arithOpT;

   typedef enum logic [2:0] {
      lAnd, lOr, lXor, lNor, lSll, lSrl, lSra
   } logicOpT;

   typedef struct packed {
      logic overflow;
      logic lessThan;
      logic equal;
   } aluFlagsT;

   typedef struct packed {
      logic useImm;  // rt replaced by extended imme
      logic signExt;
      logic shiftVar;  // shift by rs[4:0]
   } operandCtrlT;

endpackage

`default_nettype wire

/* opDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module opDecode (
   input  exeTypesPkg::exeFieldsT   fields,
   output exeTypesPkg::unitSelT     unitSel,
   output exeTypesPkg::arithOpT     arithOp,
   output exeTypesPkg::logicOpT     logicOp,
   output exeTypesPkg::operandCtrlT opCtrl
);
   import mipsIsaPkg::*;
   import exeTypesPkg::*;

   always_comb begin
      unitSel = unitNone;  // unknown encodings give zero
      arithOp = aAdd;
      logicOp = lAnd;
      opCtrl  = '0;
      case (fields.opcode)
         opRType: begin
            case (fields.funct)
               fnAdd:  begin unitSel = unitArith; arithOp = aAdd;  end
               fnAddu: begin unitSel = unitArith; arithOp = aAddu; end
               fnSub:  begin unitSel = unitArith; arithOp = aSub;  end
               fnSubu: begin unitSel = unitArith; arithOp = aSubu; end
               fnSlt:  begin unitSel = unitArith; arithOp = aSlt;  end
               fnSltu: begin unitSel = unitArith; arithOp = aSltu; end
               fnAnd:  begin unitSel = unitLogic; logicOp = lAnd;  end
               fnOr:   begin unitSel = unitLogic; logicOp = lOr;   end
               fnXor:  begin unitSel = unitLogic; logicOp = lXor;  end
               fnNor:  begin unitSel = unitLogic; logicOp = lNor;  end
               fnSll:  begin unitSel = unitLogic; logicOp = lSll;  end
               fnSrl:  begin unitSel = unitLogic; logicOp = lSrl;  end
               fnSra:  begin unitSel = unitLogic; logicOp = lSra;  end
               fnSllv, fnSrlv, fnSrav: begin
                  unitSel         = unitLogic;
                  opCtrl.shiftVar = 1'b1;
                  logicOp         = (fields.funct == fnSllv) ? lSll :
                                    (fields.funct == fnSrlv) ? lSrl : lSra;
               end
               default: unitSel = unitNone;
            endcase
         end
         opAddi, opLw, opSw: begin
            unitSel = unitArith;
            arithOp = aAdd;
            opCtrl  = '{useImm: 1'b1, signExt: 1'b1, shiftVar: 1'b0};
         end
         opAddiu: begin
            unitSel = unitArith;
            arithOp = aAddu;
            opCtrl  = '{useImm: 1'b1, signExt: 1'b1, shiftVar: 1'b0};
         end
         opSlti, opSltiu: begin
            unitSel = unitArith;
            arithOp = (fields.opcode == opSlti) ? aSlt : aSltu;
            opCtrl  = '{useImm: 1'b1, signExt: 1'b1, shiftVar: 1'b0};
         end
         opAndi, opOri, opXori: begin
            unitSel = unitLogic;
            logicOp = (fields.opcode == opAndi) ? lAnd :
                      (fields.opcode == opOri)  ? lOr  : lXor;
            opCtrl  = '{useImm: 1'b1, signExt: 1'b0, shiftVar: 1'b0};  // zero-extended
         end
         opBeq:   begin unitSel = unitArith; arithOp = aEq; end
         opBne:   begin unitSel = unitArith; arithOp = aNe; end
         opJal:   unitSel = unitLink;
         default: unitSel = unitNone;
      endcase
   end

endmodule

`default_nettype wire

/* operandSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module operandSelect (
   input  exeTypesPkg::wordT        readDataRs,
   input  exeTypesPkg::wordT        readDataRt,
   input  exeTypesPkg::wordT        wbData,
   input  exeTypesPkg::wordT        memResult,
   input  exeTypesPkg::fwdSelT      rsSource,
   input  exeTypesPkg::fwdSelT      rtSource,
   input  mipsIsaPkg::immT          imme,
   input  exeTypesPkg::operandCtrlT opCtrl,
   output exeTypesPkg::wordT        rs,
   output exeTypesPkg::wordT        rt
);
   import mipsIsaPkg::*;
   import exeTypesPkg::*;

   wordT immExt;
   wordT rtReg;

   function automatic wordT pickSource(input fwdSelT sel,
                                       input wordT   regValue,
                                       input wordT   wbValue,
                                       input wordT   memValue);
      case (sel)
         fwdWriteback: pickSource = wbValue;
         fwdMemory:    pickSource = memValue;  // EX/MEM register
         default:      pickSource = regValue;
      endcase
   endfunction

   assign immExt = opCtrl.signExt ? {{(wordW-immW){imme[immW-1]}}, imme}
                                  : {{(wordW-immW){1'b0}}, imme};

   assign rs    = pickSource(rsSource, readDataRs, wbData, memResult);
   assign rtReg = pickSource(rtSource, readDataRt, wbData, memResult);
   assign rt    = opCtrl.useImm ? immExt : rtReg;

endmodule

`default_nettype wire

/* arithUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module arithUnit (
   input  exeTypesPkg::wordT     rs,
   input  exeTypesPkg::wordT     rt,
   input  exeTypesPkg::arithOpT  arithOp,
   output exeTypesPkg::wordT     result,
   output exeTypesPkg::aluFlagsT flags
);
   import exeTypesPkg::*;

   logic           isSub;
   wordT           operandB;
   logic [wordW:0] sumExt;
   wordT           sum;
   logic           ovfRaw;
   logic           ltSigned;
   logic           ltUnsigned;
   logic           isEqual;

   assign isSub    = arithOp inside {aSub, aSubu, aSlt, aSltu};
   assign operandB = isSub ? ~rt : rt;  // two's complement via carry in
   assign sumExt   = {1'b0, rs} + {1'b0, operandB} + {{wordW{1'b0}}, isSub};
   assign sum      = sumExt[wordW-1:0];

   // same-sign inputs with a flipped sign out
   assign ovfRaw = (rs[wordW-1] == operandB[wordW-1]) && (sum[wordW-1] != rs[wordW-1]);

   assign ltSigned   = sum[wordW-1] ^ ovfRaw;
   assign ltUnsigned = ~sumExt[wordW];  // borrow
   assign isEqual    = (rs == rt);

   always_comb begin
      result = '0;
      flags  = '0;
      case (arithOp)
         aAdd, aSub: begin
            result         = sum;
            flags.overflow = ovfRaw;
         end
         aAddu, aSubu: result = sum;
         aSlt: begin
            result         = wordT'(ltSigned);
            flags.overflow = ovfRaw;
            flags.lessThan = ltSigned;
         end
         aSltu: begin
            result         = wordT'(ltUnsigned);
            flags.lessThan = ltUnsigned;
         end
         aEq: begin
            result      = wordT'(isEqual);
            flags.equal = isEqual;
         end
         aNe: begin
            result      = wordT'(!isEqual);  // branch taken when unequal
            flags.equal = isEqual;
         end
         default: result = '0;
      endcase
   end

endmodule

`default_nettype wire

/* logicShiftUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module logicShiftUnit (
   input  exeTypesPkg::wordT    rs,
   input  exeTypesPkg::wordT    rt,
   input  mipsIsaPkg::shamtT    shamt,
   input  logic                 shiftVar,
   input  exeTypesPkg::logicOpT logicOp,
   output exeTypesPkg::wordT    result
);
   import mipsIsaPkg::*;
   import exeTypesPkg::*;

   shamtT shiftAmt;

   assign shiftAmt = shiftVar ? rs[shamtW-1:0] : shamt;  // variable forms use rs

   always_comb begin
      case (logicOp)
         lAnd:    result = rs & rt;
         lOr:     result = rs | rt;
         lXor:    result = rs ^ rt;
         lNor:    result = ~(rs | rt);
         lSll:    result = rt << shiftAmt;
         lSrl:    result = rt >> shiftAmt;
         lSra:    result = wordT'($signed(rt) >>> shiftAmt);
         default: result = '0;
      endcase
   end

endmodule

`default_nettype wire

/* executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
   input  logic                   clk,
   input  logic                   rstN,
   input  exeTypesPkg::exeFieldsT fields,
   input  exeTypesPkg::wordT      readDataRs,
   input  exeTypesPkg::wordT      readDataRt,
   input  exeTypesPkg::wordT      wbData,
   input  exeTypesPkg::wordT      nextPc,
   input  exeTypesPkg::fwdSelT    rsSource,
   input  exeTypesPkg::fwdSelT    rtSource,
   output exeTypesPkg::wordT      aluResult,
   output exeTypesPkg::aluFlagsT  aluFlags
);
   import exeTypesPkg::*;

   unitSelT     unitSel;
   arithOpT     arithOp;
   logicOpT     logicOp;
   operandCtrlT opCtrl;
   wordT        rs;
   wordT        rt;
   wordT        arithResult;
   wordT        logicResult;
   aluFlagsT    arithFlags;
   wordT        nextResult;
   aluFlagsT    nextFlags;

   opDecode opDecode_inst (
      .fields (fields),
      .unitSel(unitSel),
      .arithOp(arithOp),
      .logicOp(logicOp),
      .opCtrl (opCtrl)
   );

   operandSelect operandSelect_inst (
      .readDataRs(readDataRs),
      .readDataRt(readDataRt),
      .wbData    (wbData),
      .memResult (aluResult),  // memory-stage forward
      .rsSource  (rsSource),
      .rtSource  (rtSource),
      .imme      (fields.imme),
      .opCtrl    (opCtrl),
      .rs        (rs),
      .rt        (rt)
   );

   arithUnit arithUnit_inst (
      .rs     (rs),
      .rt     (rt),
      .arithOp(arithOp),
      .result (arithResult),
      .flags  (arithFlags)
   );

   logicShiftUnit logicShiftUnit_inst (
      .rs      (rs),
      .rt      (rt),
      .shamt   (fields.shamt),
      .shiftVar(opCtrl.shiftVar),
      .logicOp (logicOp),
      .result  (logicResult)
   );

   always_comb begin
      nextFlags = '0;
      case (unitSel)
         unitArith: begin
            nextResult = arithResult;
            nextFlags  = arithFlags;
         end
         unitLogic: nextResult = logicResult;
         unitLink:  nextResult = nextPc;  // jal return address
         default:   nextResult = '0;
      endcase
   end

   // EX/MEM register
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         aluResult <= '0;
         aluFlags  <= '0;
      end else begin
         aluResult <= nextResult;
         aluFlags  <= nextFlags;
      end
   end

endmodule

`default_nettype wire

/* executeStage_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage_properties (
   input logic                  clk,
   input logic                  rstN,
   input exeTypesPkg::unitSelT  unitSel,
   input exeTypesPkg::wordT     aluResult,
   input exeTypesPkg::aluFlagsT aluFlags
);
   import exeTypesPkg::*;

   resetClear: assert property (@(posedge clk)
         !rstN |-> (aluResult == '0 && aluFlags == '0))
      else $error("EX/MEM register not clear while in reset");

   // compare flags only come from the arithmetic unit
   noCompareFlags: assert property (@(posedge clk) disable iff (!rstN)
         ($past(unitSel) inside {unitLogic, unitLink}) |->
         (!aluFlags.equal && !aluFlags.lessThan))
      else $error("equal or lessThan set after a logic or link operation");

   unknownClear: assert property (@(posedge clk) disable iff (!rstN)
         ($past(unitSel) == unitNone) |-> (aluFlags == '0))
      else $error("flags not clear after an unrecognised encoding");

endmodule

bind executeStage executeStage_properties executeStage_properties_inst (
   .clk      (clk),
   .rstN     (rstN),
   .unitSel  (unitSel),
   .aluResult(aluResult),
   .aluFlags (aluFlags)
);

`default_nettype wire

/* tbExecuteStage.sv */
`timescale 1ns/1ps
`default_nettype none

module tbExecuteStage;
   import mipsIsaPkg::*;
   import exeTypesPkg::*;

   localparam int numRandom   = 400;
   localparam int numDirected = 27;
   localparam int timeoutNs   = (numRandom + numDirected + 3) * 10 + 500;
   localparam int numEnc      = 33;

   // decoded encodings plus a few unrecognised ones as {opcode, funct}
   localparam logic [11:0] encTable [numEnc] = '{
      {opRType, fnAdd}, {opRType, fnAddu}, {opRType, fnSub}, {opRType, fnSubu},
      {opRType, fnAnd}, {opRType, fnOr}, {opRType, fnXor}, {opRType, fnNor},
      {opRType, fnSll}, {opRType, fnSrl}, {opRType, fnSra}, {opRType, fnSllv},
      {opRType, fnSrlv}, {opRType, fnSrav}, {opRType, fnSlt}, {opRType, fnSltu},
      {opRType, fnJr}, {opAddi, 6'h00}, {opAddiu, 6'h00}, {opSlti, 6'h00},
      {opSltiu, 6'h00}, {opAndi, 6'h00}, {opOri, 6'h00}, {opXori, 6'h00},
      {opLw, 6'h00}, {opSw, 6'h00}, {opBeq, 6'h00}, {opBne, 6'h00},
      {opJal, 6'h00}, {opJ, 6'h00}, {6'b111111, 6'h00}, {opRType, 6'b111111},
      {6'b010000, 6'h00}
   };

   logic      clk;
   logic      rstN;
   exeFieldsT fields;
   wordT      readDataRs;
   wordT      readDataRt;
   wordT      wbData;
   wordT      nextPc;
   fwdSelT    rsSource;
   fwdSelT    rtSource;
   wordT      aluResult;
   aluFlagsT  aluFlags;
   wordT      expResult;
   aluFlagsT  expFlags;
   wordT      predResult;
   aluFlagsT  predFlags;
   integer    seed = 12;

   executeStage executeStage_inst (
      .clk       (clk),
      .rstN      (rstN),
      .fields    (fields),
      .readDataRs(readDataRs),
      .readDataRt(readDataRt),
      .wbData    (wbData),
      .nextPc    (nextPc),
      .rsSource  (rsSource),
      .rtSource  (rtSource),
      .aluResult (aluResult),
      .aluFlags  (aluFlags)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abortRun(input string reason);
      $display("SOME TESTS FAILED");
      $fatal(1, "%s", reason);
   endtask

   // expected result and flags from the ISA rules
   function automatic void predict(input exeFieldsT f, input wordT rsReg, input wordT rtReg,
                                   input wordT wb, input wordT pc, input fwdSelT rsSel,
                                   input fwdSelT rtSel, input wordT memPrev,
                                   output wordT res, output aluFlagsT flg);
      wordT        a;
      wordT        b;
      logic [32:0] sum;
      logic [32:0] diff;
      shamtT       amt;
      a = (rsSel == fwdWriteback) ? wb : (rsSel == fwdMemory) ? memPrev : rsReg;
      b = (rtSel == fwdWriteback) ? wb : (rtSel == fwdMemory) ? memPrev : rtReg;
      if (f.opcode inside {opAndi, opOri, opXori})
         b = {16'h0000, f.imme};
      else if (f.opcode inside {opAddi, opAddiu, opSlti, opSltiu, opLw, opSw})
         b = {{16{f.imme[15]}}, f.imme};
      sum  = {a[31], a} + {b[31], b};  // 33-bit signed view
      diff = {a[31], a} - {b[31], b};
      amt  = (f.funct inside {fnSllv, fnSrlv, fnSrav}) ? a[4:0] : f.shamt;
      res  = '0;
      flg  = '0;
      case (f.opcode)
         opRType: begin
            case (f.funct)
               fnAdd:          {flg.overflow, res} = {sum[32] ^ sum[31], sum[31:0]};
               fnAddu:         res = sum[31:0];
               fnSub:          {flg.overflow, res} = {diff[32] ^ diff[31], diff[31:0]};
               fnSubu:         res = diff[31:0];
               fnAnd:          res = a & b;
               fnOr:           res = a | b;
               fnXor:          res = a ^ b;
               fnNor:          res = ~(a | b);
               fnSll, fnSllv:  res = b << amt;
               fnSrl, fnSrlv:  res = b >> amt;
               fnSra, fnSrav:  res = (b >> amt) | (b[31] ? ~(32'hffff_ffff >> amt) : '0);
               fnSlt:          flg.overflow = diff[32] ^ diff[31];
               default:        res = '0;
            endcase
            if (f.funct == fnSlt)
               flg.lessThan = $signed(a) < $signed(b);
            if (f.funct == fnSltu)
               flg.lessThan = a < b;
            if (f.funct inside {fnSlt, fnSltu})
               res = wordT'(flg.lessThan);
         end
         opAddi, opLw, opSw: {flg.overflow, res} = {sum[32] ^ sum[31], sum[31:0]};
         opAddiu: res = sum[31:0];
         opSlti: begin
            flg.overflow = diff[32] ^ diff[31];
            flg.lessThan = $signed(a) < $signed(b);
            res          = wordT'(flg.lessThan);
         end
         opSltiu: begin
            flg.lessThan = a < b;
            res          = wordT'(flg.lessThan);
         end
         opAndi:  res = a & b;
         opOri:   res = a | b;
         opXori:  res = a ^ b;
         opBeq:   {flg.equal, res} = {a == b, wordT'(a == b)};
         opBne:   {flg.equal, res} = {a == b, wordT'(a != b)};
         opJal:   res = pc;
         default: res = '0;
      endcase
   endfunction

   always_comb begin
      predict(fields, readDataRs, readDataRt, wbData, nextPc, rsSource, rtSource, expResult,
              predResult, predFlags);
   end

   // model copy of the EX/MEM register
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         expResult <= '0;
         expFlags  <= '0;
      end else begin
         expResult <= predResult;
         expFlags  <= predFlags;
      end
   end

   resultCheck: assert property (@(posedge clk) aluResult == expResult)
      else begin
         $display("MISMATCH aluResult: got %h, expected %h",
                  $sampled(aluResult), $sampled(expResult));
         abortRun("aluResult differs from the reference model");
      end

   flagsCheck: assert property (@(posedge clk) aluFlags == expFlags)
      else begin
         $display("MISMATCH aluFlags: got %h, expected %h",
                  $sampled(aluFlags), $sampled(expFlags));
         abortRun("aluFlags differ from the reference model");
      end

   task automatic issue(input opcodeT op, input functT fn, input shamtT sh, input immT im,
                        input wordT rsVal, input wordT rtVal,
                        input fwdSelT rsSel, input fwdSelT rtSel);
      fields     = '{opcode: op, funct: fn, shamt: sh, imme: im};
      readDataRs = rsVal;
      readDataRt = rtVal;
      rsSource   = rsSel;
      rtSource   = rtSel;
      wbData     = $random(seed);
      nextPc     = $random(seed);
      @(posedge clk);
      #1;
   endtask

   task automatic issueReg(input opcodeT op, input functT fn, input shamtT sh, input immT im,
                           input wordT rsVal, input wordT rtVal);
      issue(op, fn, sh, im, rsVal, rtVal, fwdRegFile, fwdRegFile);
   endtask

   initial begin
      #(timeoutNs);
      $display("timeout: run did not finish within %0d ns", timeoutNs);
      abortRun("watchdog expired");
   end

   initial begin
      logic [11:0] enc;
      immT         im;
      fields     = '0;
      readDataRs = '0;
      readDataRt = '0;
      wbData     = '0;
      nextPc     = '0;
      rsSource   = fwdRegFile;
      rtSource   = fwdRegFile;
      rstN       = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rstN = 1'b1;
      issueReg(opRType, fnAdd, '0, '0, 32'h7fff_ffff, 32'h0000_0001);  // signed limits
      issueReg(opRType, fnAddu, '0, '0, 32'h7fff_ffff, 32'h0000_0001);
      issueReg(opRType, fnSub, '0, '0, 32'h8000_0000, 32'h0000_0001);
      issueReg(opRType, fnSubu, '0, '0, 32'h8000_0000, 32'h0000_0001);
      issueReg(opRType, fnAdd, '0, '0, 32'h8000_0000, 32'h8000_0000);
      issueReg(opRType, fnSlt, '0, '0, 32'h8000_0000, 32'h0000_0001);
      issueReg(opRType, fnSltu, '0, '0, 32'hffff_fffb, 32'h0000_0003);
      issueReg(opSlti, '0, '0, 16'h8000, 32'h8000_0000, '0);
      issueReg(opSltiu, '0, '0, 16'hfff0, 32'hffff_ff00, '0);
      issueReg(opBeq, '0, '0, 16'h8000, 32'h1234_5678, 32'h1234_5678);
      issueReg(opBne, '0, '0, 16'h8000, 32'h1234_5678, 32'h1234_5678);
      issueReg(opBne, '0, '0, '0, 32'h1234_5678, 32'h0000_0001);
      issueReg(opAndi, '0, '0, 16'hf0f0, 32'hffff_ffff, '0);
      issueReg(opOri, '0, '0, 16'h8001, 32'h0000_0000, '0);
      issueReg(opXori, '0, '0, 16'hffff, 32'h5555_5555, '0);
      issueReg(opAddi, '0, '0, 16'h8001, 32'h0000_0010, '0);
      issueReg(opLw, '0, '0, 16'hfffc, 32'h1000_0000, '0);
      issueReg(opSw, '0, '0, 16'h8004, 32'h1000_0000, '0);
      issueReg(opRType, fnAdd, '0, '0, 32'h0000_0005, 32'h0000_0007);  // back-to-back forwarding
      issue(opRType, fnSub, '0, '0, '0, 32'h0000_0002, fwdMemory, fwdRegFile);
      issue(opRType, fnSllv, 5'd9, '0, 32'h0000_0003, '0, fwdRegFile, fwdMemory);
      issue(opRType, fnOr, '0, '0, '0, 32'h0000_0100, fwdWriteback, fwdRegFile);
      issue(opRType, fnXor, '0, '0, 32'h00ff_00ff, 32'h0f0f_0f0f, fwdSelT'(2'b11),
            fwdSelT'(2'b11));
      issueReg(opJal, '0, '0, '0, 32'h0000_0001, 32'h0000_0002);
      issueReg(opJ, '0, '0, '0, 32'h0000_0001, 32'h0000_0002);
      issueReg(opRType, fnJr, '0, '0, 32'h0000_0040, '0);
      issueReg(6'b111111, '0, '0, '0, 32'hffff_ffff, 32'hffff_ffff);
      for (int i = 0; i < numRandom; i++) begin
         enc = encTable[$unsigned($random(seed)) % numEnc];
         im  = immT'($random(seed));
         if (i[0])
            im[15] = 1'b1;  // negative immediates
         issue(enc[11:6], enc[5:0], shamtT'($random(seed)), im, $random(seed), $random(seed),
               fwdSelT'(2'($random(seed))), fwdSelT'(2'($random(seed))));
      end
      repeat (2) @(posedge clk);
      #1;
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* executeStage.f */
mipsIsaPkg.sv
exeTypesPkg.sv
opDecode.sv
operandSelect.sv
arithUnit.sv
logicShiftUnit.sv
executeStage.sv
executeStage_properties.sv
tbExecuteStage.sv

/* run.sh */
#!/bin/sh
# builds and runs the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir
simName=simExecuteStage

verilator --binary --timing --assert --top-module tbExecuteStage \
   -f executeStage.f --Mdir "$buildDir" -o "$simName"
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
status=$?
cat "$logFile"

if grep -q "SOME TESTS FAILED" "$logFile"; then
   echo "run failed, see $logFile"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
echo "run passed"
exit 0
